// ==== verilog/mazePkg.sv ====
`default_nettype none

package mazePkg;

    // Navigation states, spare codes left for later additions
    typedef enum logic [4:0] {
        stIdle        = 5'd0,
        stStart       = 5'd1,
        stCount       = 5'd2,
        stStraight    = 5'd3,
        stChoose      = 5'd4,
        stLeft        = 5'd5,
        stRight       = 5'd6,
        stBack        = 5'd7,
        stLittleLeft  = 5'd8,
        stLittleRight = 5'd9,
        stFinish      = 5'd29,
        stStop        = 5'd30,
        stError       = 5'd31
    } navState_t;

    // Sensor word read as {left, middle, right}
    typedef logic [2:0] roadPattern_t;

    localparam roadPattern_t errorRoad       = 3'b000;
    localparam roadPattern_t rightLittleRoad = 3'b001;
    localparam roadPattern_t straightRoad    = 3'b010;
    localparam roadPattern_t rightRoad       = 3'b011;
    localparam roadPattern_t leftLittleRoad  = 3'b100;
    localparam roadPattern_t turnRoad101     = 3'b101;
    localparam roadPattern_t leftRoad        = 3'b110;
    localparam roadPattern_t turnRoad111     = 3'b111;

    // Stack entry codes
    typedef enum logic [1:0] {
        codeEmpty    = 2'd0,
        junctionMark = 2'd1,
        turnLeft     = 2'd2,
        turnRight    = 2'd3
    } turnCode_t;

    typedef enum logic [2:0] {halt, forward, reverse, spinLeft, spinRight} motion_t;

    typedef enum logic [1:0] {steerNone, steerLeft, steerRight} steer_t;

    typedef struct packed {
        motion_t motion;
        steer_t  steer;
    } driveCmd_t;

    // Junction checkpoints plus the right-turn crossing result
    typedef struct packed {
        logic cp1;
        logic cp2;
        logic cp3;
        logic cp4;
        logic cp5;
        logic rightDone;
    } checkpoints_t;

    localparam int START_WAIT_CYCLES = 16;
    localparam int STOP_WAIT_CYCLES  = 8;
    localparam int ROUTE_DEPTH       = 32;

    typedef logic [$clog2(ROUTE_DEPTH)-1:0] routeIndex_t;

endpackage

`default_nettype wire

// ==== verilog/lineDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module lineDecoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sensorValid,
    input  mazePkg::roadPattern_t sensorBits,
    output mazePkg::roadPattern_t pattern,
    output logic                  crossingRise
);
    import mazePkg::*;

    logic newCrossing;

    // A crossing starts when a full-bar word replaces any other word
    assign newCrossing = sensorValid && (sensorBits == turnRoad111) &&
                         (pattern != turnRoad111);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern      <= errorRoad;
            crossingRise <= 1'b0;
        end else begin
            crossingRise <= newCrossing;
            // Word is held between strobes
            if (sensorValid) begin
                pattern <= sensorBits;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/checkpointTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module checkpointTracker (
    input  logic                  clk,
    input  logic                  rst,
    input  mazePkg::navState_t    state,
    input  mazePkg::roadPattern_t pattern,
    input  logic                  crossingRise,
    output mazePkg::checkpoints_t flags
);
    import mazePkg::*;

    navState_t  lastState;
    logic [1:0] rightCount;
    logic       straightFamily;
    logic       countStep;

    assign straightFamily = (state == stStraight) || (state == stLittleLeft) ||
                            (state == stLittleRight);

    // Crossings only count once the spin has left the junction bar
    assign countStep = (state == stRight) && flags.cp4 && crossingRise;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lastState  <= stIdle;
            flags      <= '0;
            rightCount <= 2'd0;
        end else begin
            lastState <= state;

            if (state == stChoose && pattern != turnRoad111) flags.cp1 <= 1'b1;
            else if (state != stChoose) flags.cp1 <= 1'b0;

            // Armed right after the count-down or once off a crossing
            if (lastState == stCount || (straightFamily && pattern != turnRoad111)) begin
                flags.cp2 <= 1'b1;
            end else if (!straightFamily) begin
                flags.cp2 <= 1'b0;
            end

            if (state == stLeft && pattern != turnRoad111) flags.cp3 <= 1'b1;
            else if (state != stLeft) flags.cp3 <= 1'b0;

            if (state == stRight && pattern != turnRoad111) flags.cp4 <= 1'b1;
            else if (state != stRight) flags.cp4 <= 1'b0;

            if (state == stLeft && pattern != turnRoad101) flags.cp5 <= 1'b1;
            else if (state != stLeft) flags.cp5 <= 1'b0;

            if (state != stRight) begin
                rightCount      <= 2'd0;
                flags.rightDone <= 1'b0;
            end else begin
                if (countStep) begin
                    rightCount <= rightCount + 2'd1;
                end
                if (rightCount >= 2'd2) begin
                    flags.rightDone <= 1'b1;
                end
            end
        end
    end

    // The controller must leave the right spin before a fourth crossing
    assert property (@(posedge clk) disable iff (rst)
        !(countStep && rightCount == 2'd3));

endmodule

`default_nettype wire

// ==== verilog/phaseTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phaseTimer #(
    parameter int LENGTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic done
);

    logic [$clog2(LENGTH)-1:0] count;
    logic                      atLast;

    assign atLast = (int'(count) == LENGTH - 1);
    assign done   = run && atLast;

    // Count restarts from zero each time the phase is entered
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (!run || atLast) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // The timed phase ends on the edge that follows done
    assert property (@(posedge clk) disable iff (rst) done |=> !run);

endmodule

`default_nettype wire

// ==== verilog/navController.sv ====
`timescale 1ns/1ps
`default_nettype none

module navController (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  logic                  obstacleNear,
    input  mazePkg::roadPattern_t pattern,
    input  mazePkg::checkpoints_t flags,
    input  logic                  countDone,
    input  logic                  stopDone,
    input  mazePkg::turnCode_t    topCode,
    output mazePkg::navState_t    state,
    output mazePkg::driveCmd_t    drive,
    output logic                  push,
    output logic                  rewrite,
    output mazePkg::turnCode_t    writeCode
);
    import mazePkg::*;

    navState_t nextState;
    navState_t resumeState;
    navState_t nextResume;
    logic      pushReq;
    logic      rewriteReq;
    logic      advance;

    // Enable drop and obstacle override the road-driven transition
    assign advance = enable && !(obstacleNear && state != stIdle);
    assign push    = pushReq && advance;
    assign rewrite = rewriteReq && advance;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= stIdle;
            resumeState <= stStraight;
        end else if (!enable) begin
            state <= stIdle;
        end else if (obstacleNear && state != stIdle) begin
            state <= stFinish;
        end else begin
            state       <= nextState;
            resumeState <= nextResume;
        end
    end

    always_comb begin
        nextState  = state;
        nextResume = resumeState;
        pushReq    = 1'b0;
        rewriteReq = 1'b0;
        writeCode  = codeEmpty;
        case (state)
            stIdle:  nextState = stStart;
            stStart: if (pattern == straightRoad) nextState = stCount;
            stCount: if (countDone) nextState = stStraight;
            stStraight, stLittleLeft, stLittleRight: begin
                case (pattern)
                    errorRoad: begin
                        nextState  = stStop;
                        nextResume = stBack;
                    end
                    turnRoad111:                nextState = flags.cp2 ? stChoose : stStraight;
                    leftRoad, leftLittleRoad:   nextState = stLittleLeft;
                    rightRoad, rightLittleRoad: nextState = stLittleRight;
                    default:                    nextState = stStraight;
                endcase
            end
            stChoose: begin
                if (pattern == turnRoad101) begin
                    nextState  = stStop;
                    nextResume = stLeft;
                end else if (pattern == turnRoad111 && flags.cp1) begin
                    nextState = stStraight;
                    pushReq   = 1'b1;
                    writeCode = junctionMark;
                end
            end
            stLeft: begin
                if (pattern == turnRoad101 && flags.cp5) begin
                    nextState  = stStop;
                    nextResume = stRight;
                end else if (pattern == turnRoad111 && flags.cp3) begin
                    nextState  = stStop;
                    nextResume = stStraight;
                end
            end
            stRight: begin
                if (pattern == turnRoad111 && flags.cp4 && flags.rightDone) begin
                    nextState  = stStop;
                    nextResume = stStraight;
                end else if (pattern == turnRoad101 && flags.rightDone) begin
                    nextState = stError;
                end
            end
            stBack: begin
                // Back at a junction, try the next untried branch
                if (pattern == turnRoad111) begin
                    nextState = stStop;
                    if (topCode == junctionMark) begin
                        rewriteReq = 1'b1;
                        writeCode  = turnLeft;
                        nextResume = stLeft;
                    end else if (topCode == turnLeft) begin
                        rewriteReq = 1'b1;
                        writeCode  = turnRight;
                        nextResume = stRight;
                    end else begin
                        nextResume = stStraight;
                    end
                end
            end
            stStop:  if (stopDone) nextState = resumeState;
            default: nextState = state;
        endcase
    end

    always_comb begin
        drive.motion = halt;
        drive.steer  = steerNone;
        case (state)
            stStraight, stChoose: drive.motion = forward;
            stLittleLeft: begin
                drive.motion = forward;
                drive.steer  = steerLeft;
            end
            stLittleRight: begin
                drive.motion = forward;
                drive.steer  = steerRight;
            end
            stLeft:  drive.motion = spinLeft;
            stRight: drive.motion = spinRight;
            stBack:  drive.motion = reverse;
            default: drive.motion = halt;
        endcase
    end

    // A done strobe outside its own phase would be lost
    assert property (@(posedge clk) disable iff (rst) countDone |-> state == stCount);
    assert property (@(posedge clk) disable iff (rst) stopDone |-> state == stStop);

endmodule

`default_nettype wire

// ==== verilog/routeMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module routeMemory (
    input  logic               clk,
    input  logic               rst,
    input  mazePkg::navState_t state,
    input  logic               push,
    input  logic               rewrite,
    input  mazePkg::turnCode_t writeCode,
    output mazePkg::turnCode_t topCode,
    output logic               routeValid,
    output mazePkg::turnCode_t routeCode,
    output logic               routeDone
);
    import mazePkg::*;

    // One bit wider than the stack index so a full stack replay terminates
    typedef logic [$bits(routeIndex_t):0] replayPtr_t;

    turnCode_t   routeMem [ROUTE_DEPTH];
    routeIndex_t topIndex;
    routeIndex_t nextIndex;
    replayPtr_t  replayPtr;
    replayPtr_t  visitIdx;
    turnCode_t   visitCode;
    logic        inFinish;
    logic        wasFinish;
    logic        replayStart;
    logic        replayActive;
    logic        visiting;

    assign nextIndex = topIndex + routeIndex_t'(1);

    // Entry 0 is the stack base and always reads empty
    assign topCode = (topIndex == '0) ? codeEmpty : routeMem[topIndex];

    assign inFinish    = (state == stFinish);
    assign replayStart = inFinish && !wasFinish;
    assign visitIdx    = replayStart ? replayPtr_t'(1) : replayPtr;
    assign visitCode   = routeMem[visitIdx[$bits(routeIndex_t)-1:0]];
    assign visiting    = (replayStart || replayActive) && (visitIdx <= {1'b0, topIndex});

    always_ff @(posedge clk) begin
        if (push) begin
            routeMem[nextIndex] <= writeCode;
        end else if (rewrite) begin
            routeMem[topIndex] <= writeCode;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            topIndex <= '0;
        end else if (push) begin
            topIndex <= nextIndex;
        end
    end

    // Replay walks entries 1 up to the top, one per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wasFinish    <= 1'b0;
            replayActive <= 1'b0;
            replayPtr    <= '0;
            routeValid   <= 1'b0;
            routeDone    <= 1'b0;
        end else begin
            wasFinish  <= inFinish;
            routeValid <= 1'b0;
            if (!inFinish) begin
                replayActive <= 1'b0;
                routeDone    <= 1'b0;
            end else if (visiting) begin
                routeValid   <= (visitCode != codeEmpty);
                replayPtr    <= visitIdx + replayPtr_t'(1);
                replayActive <= 1'b1;
            end else if (replayStart || replayActive) begin
                replayActive <= 1'b0;
                routeDone    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (visiting) begin
            routeCode <= visitCode;
        end
    end

    // Controller must never try to grow a full stack
    assert property (@(posedge clk) disable iff (rst)
        !(push && topIndex == routeIndex_t'(ROUTE_DEPTH - 1)));

endmodule

`default_nettype wire

// ==== verilog/mazeNavigator.sv ====
`timescale 1ns/1ps
`default_nettype none

module mazeNavigator (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  logic                  obstacleNear,
    input  logic                  sensorValid,
    input  mazePkg::roadPattern_t sensorBits,
    output mazePkg::navState_t    state,
    output mazePkg::driveCmd_t    drive,
    output logic                  routeValid,
    output mazePkg::turnCode_t    routeCode,
    output logic                  routeDone
);
    import mazePkg::*;

    roadPattern_t pattern;
    logic         crossingRise;
    checkpoints_t flags;
    logic         countRun;
    logic         countDone;
    logic         stopRun;
    logic         stopDone;
    logic         push;
    logic         rewrite;
    turnCode_t    writeCode;
    turnCode_t    topCode;

    // Timers run only while their phase is active
    assign countRun = (state == stCount);
    assign stopRun  = (state == stStop);

    lineDecoder lineDecoder_i (
        .clk          (clk),
        .rst          (rst),
        .sensorValid  (sensorValid),
        .sensorBits   (sensorBits),
        .pattern      (pattern),
        .crossingRise (crossingRise)
    );

    checkpointTracker checkpointTracker_i (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .pattern      (pattern),
        .crossingRise (crossingRise),
        .flags        (flags)
    );

    phaseTimer #(.LENGTH(START_WAIT_CYCLES)) countTimer (
        .clk  (clk),
        .rst  (rst),
        .run  (countRun),
        .done (countDone)
    );

    phaseTimer #(.LENGTH(STOP_WAIT_CYCLES)) pauseTimer (
        .clk  (clk),
        .rst  (rst),
        .run  (stopRun),
        .done (stopDone)
    );

    navController navController_i (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .obstacleNear (obstacleNear),
        .pattern      (pattern),
        .flags        (flags),
        .countDone    (countDone),
        .stopDone     (stopDone),
        .topCode      (topCode),
        .state        (state),
        .drive        (drive),
        .push         (push),
        .rewrite      (rewrite),
        .writeCode    (writeCode)
    );

    routeMemory routeMemory_i (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .push       (push),
        .rewrite    (rewrite),
        .writeCode  (writeCode),
        .topCode    (topCode),
        .routeValid (routeValid),
        .routeCode  (routeCode),
        .routeDone  (routeDone)
    );

endmodule

`default_nettype wire

// ==== verif/mazeNavigatorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mazeNavigatorTb;
    import mazePkg::*;

    // Cycle budget per test, summed and doubled for the run limit
    localparam int RESET_CYCLES  = 4;
    localparam int START_CYCLES  = 8 + START_WAIT_CYCLES;
    localparam int STEER_CYCLES  = 12;
    localparam int JUNCT_CYCLES  = 12;
    localparam int BACK_CYCLES   = 8 + 2 * STOP_WAIT_CYCLES;
    localparam int REPLAY_CYCLES = 8 + ROUTE_DEPTH;
    localparam int OFF_CYCLES    = 10 + START_WAIT_CYCLES;
    localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + START_CYCLES + STEER_CYCLES +
                                   JUNCT_CYCLES + BACK_CYCLES + REPLAY_CYCLES + OFF_CYCLES);

    logic         clk;
    logic         rst;
    logic         enable;
    logic         obstacleNear;
    logic         sensorValid;
    roadPattern_t sensorBits;
    navState_t    state;
    driveCmd_t    drive;
    logic         routeValid;
    turnCode_t    routeCode;
    logic         routeDone;

    int cycleCount = 0;
    int passCount  = 0;
    int failCount  = 0;

    // Expected stack contents, bottom entry first
    turnCode_t routeModel[$];

    mazeNavigator mazeNavigator_i (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .obstacleNear (obstacleNear),
        .sensorValid  (sensorValid),
        .sensorBits   (sensorBits),
        .state        (state),
        .drive        (drive),
        .routeValid   (routeValid),
        .routeCode    (routeCode),
        .routeDone    (routeDone)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic driveCmd_t makeDrive(motion_t m, steer_t s);
        driveCmd_t cmd;
        cmd.motion = m;
        cmd.steer  = s;
        return cmd;
    endfunction

    task automatic compareState(string name, navState_t got, navState_t exp);
        if (got === exp) begin
            passCount++;
        end else begin
            failCount++;
            $display("Fail %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic compareDrive(string name, driveCmd_t got, driveCmd_t exp);
        motion_t gotMotion;
        motion_t expMotion;
        steer_t  gotSteer;
        steer_t  expSteer;
        gotMotion = got.motion;
        expMotion = exp.motion;
        gotSteer  = got.steer;
        expSteer  = exp.steer;
        if (got === exp) begin
            passCount++;
        end else begin
            failCount++;
            $display("Fail %0t: %s got %s/%s expected %s/%s", $time, name,
                     gotMotion.name(), gotSteer.name(), expMotion.name(), expSteer.name());
        end
    endtask

    task automatic compareRoute(string name, turnCode_t got, turnCode_t exp);
        if (got === exp) begin
            passCount++;
        end else begin
            failCount++;
            $display("Fail %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic reportProblem(string msg);
        failCount++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic finishTest(string name, int failsBefore);
        if (failCount == failsBefore) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, failCount - failsBefore);
        end
    endtask

    // Sample point is the falling edge after the n-th rising edge
    task automatic waitEdges(int n);
        repeat (n) @(posedge clk);
        @(negedge clk);
    endtask

    // One strobe, then sample n edges after the capture edge counts as one
    task automatic applySensor(roadPattern_t word, int cycles);
        @(posedge clk);
        sensorBits  <= word;
        sensorValid <= 1'b1;
        @(posedge clk);
        sensorValid <= 1'b0;
        waitEdges(cycles - 1);
    endtask

    task automatic waitState(navState_t target, int limit);
        int waited;
        waited = 0;
        while (state !== target && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (state !== target) begin
            reportProblem($sformatf("state never reached %s", target.name()));
        end
    endtask

    task automatic modelPush(turnCode_t code);
        routeModel.push_back(code);
    endtask

    task automatic modelRewrite(turnCode_t code);
        if (routeModel.size() == 0) begin
            reportProblem("route model rewrite on an empty stack");
        end else begin
            routeModel[routeModel.size() - 1] = code;
        end
    endtask

    task automatic resetAndStart();
        int failsBefore;
        failsBefore = failCount;
        @(negedge clk);
        compareState("state", state, stIdle);
        compareDrive("drive", drive, makeDrive(halt, steerNone));
        @(posedge clk);
        enable <= 1'b1;
        applySensor(straightRoad, 1);
        compareState("state", state, stStart);
        waitEdges(1);
        compareState("state", state, stCount);
        // Count-down holds for exactly its length
        waitEdges(START_WAIT_CYCLES - 1);
        compareState("state", state, stCount);
        waitEdges(1);
        compareState("state", state, stStraight);
        compareDrive("drive", drive, makeDrive(forward, steerNone));
        finishTest("reset and start", failsBefore);
    endtask

    task automatic steeringCorrections();
        int failsBefore;
        failsBefore = failCount;
        applySensor(leftRoad, 2);
        compareState("state", state, stLittleLeft);
        compareDrive("drive", drive, makeDrive(forward, steerLeft));
        applySensor(rightRoad, 2);
        compareState("state", state, stLittleRight);
        compareDrive("drive", drive, makeDrive(forward, steerRight));
        applySensor(straightRoad, 2);
        compareState("state", state, stStraight);
        compareDrive("drive", drive, makeDrive(forward, steerNone));
        finishTest("steering corrections", failsBefore);
    endtask

    task automatic junctionPass();
        int failsBefore;
        failsBefore = failCount;
        applySensor(turnRoad111, 2);
        compareState("state", state, stChoose);
        compareDrive("drive", drive, makeDrive(forward, steerNone));
        // Gap in the bar arms the junction checkpoint
        applySensor(errorRoad, 2);
        compareState("state", state, stChoose);
        applySensor(turnRoad111, 2);
        modelPush(junctionMark);
        compareState("state", state, stStraight);
        compareDrive("drive", drive, makeDrive(forward, steerNone));
        finishTest("junction pass", failsBefore);
    endtask

    task automatic deadEndBacktrack();
        int        failsBefore;
        navState_t expResume;
        driveCmd_t expDrive;
        failsBefore = failCount;
        applySensor(errorRoad, 2);
        compareState("state", state, stStop);
        compareDrive("drive", drive, makeDrive(halt, steerNone));
        waitEdges(STOP_WAIT_CYCLES - 1);
        compareState("state", state, stStop);
        waitEdges(1);
        compareState("state", state, stBack);
        compareDrive("drive", drive, makeDrive(reverse, steerNone));

        // Next branch follows from the top of the stack
        expResume = stStraight;
        expDrive  = makeDrive(forward, steerNone);
        if (routeModel.size() > 0 && routeModel[routeModel.size() - 1] == junctionMark) begin
            modelRewrite(turnLeft);
            expResume = stLeft;
            expDrive  = makeDrive(spinLeft, steerNone);
        end else if (routeModel.size() > 0 &&
                     routeModel[routeModel.size() - 1] == turnLeft) begin
            modelRewrite(turnRight);
            expResume = stRight;
            expDrive  = makeDrive(spinRight, steerNone);
        end
        applySensor(turnRoad111, 2);
        compareState("state", state, stStop);
        waitEdges(STOP_WAIT_CYCLES);
        compareState("state", state, expResume);
        compareDrive("drive", drive, expDrive);
        finishTest("dead end and backtrack", failsBefore);
    endtask

    task automatic finishReplay();
        int failsBefore;
        int seen;
        int waited;
        failsBefore = failCount;
        seen        = 0;
        waited      = 0;
        @(posedge clk);
        obstacleNear <= 1'b1;
        waitEdges(1);
        compareState("state", state, stFinish);
        compareDrive("drive", drive, makeDrive(halt, steerNone));
        while (!routeDone && waited < ROUTE_DEPTH + 4) begin
            @(negedge clk);
            waited++;
            if (routeValid) begin
                if (seen < routeModel.size()) begin
                    compareRoute("routeCode", routeCode, routeModel[seen]);
                end else begin
                    reportProblem("replay produced more entries than were stored");
                end
                seen++;
            end
        end
        if (!routeDone) begin
            reportProblem("routeDone never rose after the replay");
        end
        if (seen != routeModel.size()) begin
            reportProblem($sformatf("replay gave %0d entries instead of %0d",
                                    seen, routeModel.size()));
        end
        repeat (2) begin
            @(negedge clk);
            if (!routeDone) begin
                reportProblem("routeDone dropped while still in finish");
            end
        end
        compareState("state", state, stFinish);
        finishTest("finish and replay", failsBefore);
    endtask

    task automatic disableRun();
        int failsBefore;
        failsBefore = failCount;
        @(posedge clk);
        enable       <= 1'b0;
        obstacleNear <= 1'b0;
        waitEdges(1);
        compareState("state", state, stIdle);
        compareDrive("drive", drive, makeDrive(halt, steerNone));

        // Drive forward again, then drop enable mid-run
        @(posedge clk);
        enable <= 1'b1;
        applySensor(straightRoad, 2);
        compareState("state", state, stCount);
        waitState(stStraight, START_WAIT_CYCLES + 2);
        compareDrive("drive", drive, makeDrive(forward, steerNone));
        @(posedge clk);
        enable <= 1'b0;
        waitEdges(1);
        compareState("state", state, stIdle);
        compareDrive("drive", drive, makeDrive(halt, steerNone));
        finishTest("disable", failsBefore);
    endtask

    initial begin
        rst          <= 1'b1;
        enable       <= 1'b0;
        obstacleNear <= 1'b0;
        sensorValid  <= 1'b0;
        sensorBits   <= errorRoad;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        resetAndStart();
        steeringCorrections();
        junctionPass();
        deadEndBacktrack();
        finishReplay();
        disableRun();

        $display("Checks passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mazeNavigator.f ====
verilog/mazePkg.sv
verilog/lineDecoder.sv
verilog/checkpointTracker.sv
verilog/phaseTimer.sv
verilog/navController.sv
verilog/routeMemory.sv
verilog/mazeNavigator.sv
verif/mazeNavigatorTb.sv

// ==== Makefile ====
TOP = mazeNavigatorTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f mazeNavigator.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f mazeNavigator.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
